// ==== all.f ====
logic/fp_mul_pkg.sv
logic/fp_mul_booth.sv
logic/fp_mul_norm.sv
logic/fp_mul_round.sv
logic/fp_mul_exp.sv
logic/fp_mul_top.sv
verification/fp_mul_assertions.sv
verification/fp_mul_monitor.sv
verification/fp_mul_tb.sv

// ==== logic/fp_mul_booth.sv ====
`timescale 1ns/1ps

module fp_mul_booth (
    input  logic [fp_mul_pkg::frac_w:0]   sig_a,
    input  logic [fp_mul_pkg::frac_w:0]   sig_b,
    output logic [fp_mul_pkg::prod_w-1:0] prod_full
);

    // One extra digit covers the top bit of the unsigned multiplier
    localparam int n_digits = (fp_mul_pkg::frac_w + 3) / 2;

    // Multiplier padded with a zero below bit 0 and zeros above the MSB
    localparam int pad_w = 2 * n_digits + 1;

    // Width of a signed multiple, large enough for -2a and +2a
    localparam int mult_w = fp_mul_pkg::frac_w + 3;

    logic [pad_w-1:0]              b_pad;
    logic [n_digits-1:0]           bd_neg;
    logic [n_digits-1:0]           bd_one;
    logic [n_digits-1:0]           bd_two;
    logic [fp_mul_pkg::prod_w-1:0] pp_ext [n_digits];
    logic [fp_mul_pkg::prod_w-1:0] pp_sum;

    // Implicit zero at bit -1 and zero extension on top
    assign b_pad = {{(pad_w - fp_mul_pkg::frac_w - 2){1'b0}}, sig_b, 1'b0};

    genvar gi;
    generate
        for (gi = 0; gi < n_digits; gi++) begin : g_digit
            logic [2:0]        tri_bits;
            logic [mult_w-1:0] pp_mag;
            logic [mult_w-1:0] pp_sv;

            // Overlapping triplet b[2i+1], b[2i], b[2i-1]
            assign tri_bits = b_pad[2*gi +: 3];

            // Digit decode into sign, x1 and x2 selects
            // 111 is a negative zero, treat it as plain zero
            assign bd_neg[gi] = tri_bits[2] & ~(tri_bits[1] & tri_bits[0]);
            assign bd_one[gi] = tri_bits[1] ^ tri_bits[0];
            assign bd_two[gi] = (tri_bits == 3'b011) | (tri_bits == 3'b100);

            // Magnitude of the selected multiple
            always_comb begin
                if (bd_two[gi]) begin
                    pp_mag = {1'b0, sig_a, 1'b0};
                end else if (bd_one[gi]) begin
                    pp_mag = {2'b00, sig_a};
                end else begin
                    pp_mag = '0;
                end
            end

            // Two's complement for negative digits
            assign pp_sv = bd_neg[gi] ? (~pp_mag + 1'b1) : pp_mag;

            // Sign extend to the product width and weight by 4^i
            assign pp_ext[gi] = {{(fp_mul_pkg::prod_w - mult_w){pp_sv[mult_w-1]}}, pp_sv}
                                << (2 * gi);
        end
    endgenerate

    // Sum of the partial products
    // Result is non-negative and fits, so the modulo sum is exact
    always_comb begin
        pp_sum = '0;
        for (int i = 0; i < n_digits; i++) begin
            pp_sum = pp_sum + pp_ext[i];
        end
    end

    assign prod_full = pp_sum;

endmodule

// ==== logic/fp_mul_exp.sv ====
`timescale 1ns/1ps

module fp_mul_exp (
    input  logic [31:0]                   op_x,
    input  logic [31:0]                   op_y,
    output fp_mul_pkg::op_class_e         class_x,
    output fp_mul_pkg::op_class_e         class_y,
    input  logic [fp_mul_pkg::exp_w-1:0]  exp_x,
    input  logic [fp_mul_pkg::exp_w-1:0]  exp_y,
    input  fp_mul_pkg::op_class_e         cls_x_r,
    input  fp_mul_pkg::op_class_e         cls_y_r,
    input  logic                          sign,
    input  logic                          norm_n,
    input  logic                          norm_r,
    input  logic [fp_mul_pkg::frac_w-1:0] frac_rnd,
    output logic [31:0]                   res,
    output logic                          ovrf,
    output logic                          udrf,
    output logic                          zer,
    output logic                          inf,
    output logic                          nan
);

    // Two spare bits hold the sum of two exponents plus both carries
    localparam int sum_w = fp_mul_pkg::exp_w + 2;

    // Biased limits expressed before the bias is removed
    localparam logic [sum_w-1:0] ovf_lim = sum_w'(255 + fp_mul_pkg::exp_bias);
    localparam logic [sum_w-1:0] udf_lim = sum_w'(fp_mul_pkg::exp_bias);

    logic [sum_w-1:0]               exp_raw;
    logic [fp_mul_pkg::exp_w-1:0]   exp_res;
    logic                           both_normal;
    logic                           any_nan;
    logic                           any_inf;
    logic                           any_zero;

    // Operand decode, subnormals count as zero
    function automatic fp_mul_pkg::op_class_e classify(input logic [31:0] op);
        logic [fp_mul_pkg::exp_w-1:0]  e;
        logic [fp_mul_pkg::frac_w-1:0] f;
        e = op[30:23];
        f = op[22:0];
        if (e == '0) begin
            return fp_mul_pkg::zero;
        end else if (e == fp_mul_pkg::exp_max) begin
            return (f == '0) ? fp_mul_pkg::infinite : fp_mul_pkg::nan;
        end
        return fp_mul_pkg::normal;
    endfunction

    // Stage 1 side, raw operands
    assign class_x = classify(op_x);
    assign class_y = classify(op_y);

    // Stage 2 side, exponent sum with the normalize and round carries
    assign exp_raw = {2'b00, exp_x} + {2'b00, exp_y}
                   + {{(sum_w - 1){1'b0}}, norm_n} + {{(sum_w - 1){1'b0}}, norm_r};
    assign exp_res = exp_raw[fp_mul_pkg::exp_w-1:0] - fp_mul_pkg::exp_w'(fp_mul_pkg::exp_bias);

    // Range checks only make sense for two finite nonzero operands
    assign both_normal = (cls_x_r == fp_mul_pkg::normal) && (cls_y_r == fp_mul_pkg::normal);
    assign ovrf        = both_normal && (exp_raw >= ovf_lim);
    assign udrf        = both_normal && (exp_raw <= udf_lim);

    assign any_nan  = (cls_x_r == fp_mul_pkg::nan) || (cls_y_r == fp_mul_pkg::nan);
    assign any_inf  = (cls_x_r == fp_mul_pkg::infinite) || (cls_y_r == fp_mul_pkg::infinite);
    assign any_zero = (cls_x_r == fp_mul_pkg::zero) || (cls_y_r == fp_mul_pkg::zero);

    // Flag precedence: NaN, then infinity, then zero
    // Infinity times zero is invalid and gives NaN
    assign nan = any_nan || (any_inf && any_zero);
    assign inf = !nan && (any_inf || ovrf);
    assign zer = !nan && !inf && (any_zero || udrf);

    // Final word
    always_comb begin
        if (nan) begin
            res = fp_mul_pkg::qnan;
        end else if (inf) begin
            res = {sign, fp_mul_pkg::exp_max, {fp_mul_pkg::frac_w{1'b0}}};
        end else if (zer) begin
            res = {sign, 31'b0};
        end else begin
            res = {sign, exp_res, frac_rnd};
        end
    end

endmodule

// ==== logic/fp_mul_norm.sv ====
`timescale 1ns/1ps

module fp_mul_norm (
    input  logic [fp_mul_pkg::prod_w-1:0] prod_full,
    output logic [fp_mul_pkg::norm_w-1:0] frac_norm,
    output logic                          norm_n
);

    // Bits kept above the sticky: hidden, fraction, guard, round
    localparam int keep_w = fp_mul_pkg::norm_w - 1;

    // Bits folded into the sticky
    localparam int drop_w = fp_mul_pkg::prod_w - keep_w;

    logic [fp_mul_pkg::prod_w-1:0] prod_al;
    logic                          sticky;

    // Product of two values in [1,2) lies in [1,4)
    // MSB set means the product is in [2,4) and the exponent grows by one
    assign norm_n = prod_full[fp_mul_pkg::prod_w-1];

    // Align the leading one to bit 47
    assign prod_al = norm_n ? prod_full
                            : {prod_full[fp_mul_pkg::prod_w-2:0], 1'b0};

    // Anything below the round bit only matters as nonzero or not
    assign sticky = |prod_al[drop_w-1:0];

    assign frac_norm = {prod_al[fp_mul_pkg::prod_w-1 -: keep_w], sticky};

endmodule

// ==== logic/fp_mul_pkg.sv ====
package fp_mul_pkg;

    // IEEE-754 single precision field widths
    localparam int exp_w  = 8;
    localparam int frac_w = 23;

    // Full significand product, two 24-bit significands
    localparam int prod_w = 48;

    // Normalized significand: hidden bit, fraction, guard, round, sticky
    localparam int norm_w = 27;

    // Exponent bias of the single format
    localparam int exp_bias = 127;

    // All-ones exponent, shared by infinity and NaN
    localparam logic [exp_w-1:0] exp_max = 8'hff;

    // Canonical quiet NaN, every NaN result takes this word
    localparam logic [31:0] qnan = 32'h7fc00000;

    // Rounding modes as seen on the rnd_mode port
    // Unused encodings fall back to ties-to-even
    typedef enum logic [2:0] {
        rne = 3'b000,
        rtz = 3'b001,
        rdn = 3'b010,
        rup = 3'b011,
        rmm = 3'b100
    } rnd_mode_e;

    // Operand class after decode
    // Subnormals are flushed, so they land in zero
    typedef enum logic [1:0] {
        zero     = 2'd0,
        normal   = 2'd1,
        infinite = 2'd2,
        nan      = 2'd3
    } op_class_e;

endpackage

// ==== logic/fp_mul_round.sv ====
`timescale 1ns/1ps

module fp_mul_round (
    input  logic [fp_mul_pkg::norm_w-1:0] frac_norm,
    input  logic                          sign,
    input  fp_mul_pkg::rnd_mode_e         rnd_mode,
    output logic [fp_mul_pkg::frac_w-1:0] frac_rnd,
    output logic                          norm_r
);

    logic [fp_mul_pkg::frac_w:0]   sig_trunc;
    logic [fp_mul_pkg::frac_w+1:0] sig_inc;
    logic                          lsb;
    logic                          guard;
    logic                          rs_any;
    logic                          inexact;
    logic                          inc;

    // Hidden bit plus fraction, guard and sticky dropped
    assign sig_trunc = frac_norm[fp_mul_pkg::norm_w-1:3];

    // Fraction LSB decides ties in ties-to-even
    assign lsb   = frac_norm[3];
    assign guard = frac_norm[2];

    // Round and sticky bits act as one sticky
    assign rs_any  = |frac_norm[1:0];
    assign inexact = guard | rs_any;

    // Increment decision
    always_comb begin
        case (rnd_mode)
            fp_mul_pkg::rtz: begin
                inc = 1'b0;
            end
            fp_mul_pkg::rdn: begin
                // Away from zero only for negative results
                inc = sign & inexact;
            end
            fp_mul_pkg::rup: begin
                inc = ~sign & inexact;
            end
            fp_mul_pkg::rmm: begin
                // Ties go away from zero
                inc = guard;
            end
            default: begin
                // Ties to even, also for unused encodings
                inc = guard & (rs_any | lsb);
            end
        endcase
    end

    // One extra bit catches the carry out of the 24-bit significand
    assign sig_inc = {1'b0, sig_trunc} + {{(fp_mul_pkg::frac_w + 1){1'b0}}, inc};

    // Carry means 1.111..1 rolled over to 10.000..0
    assign norm_r = sig_inc[fp_mul_pkg::frac_w+1];

    // Fraction bits are all zero on carry
    assign frac_rnd = sig_inc[fp_mul_pkg::frac_w-1:0];

endmodule

// ==== logic/fp_mul_top.sv ====
`timescale 1ns/1ps

module fp_mul_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [31:0]           op_x,
    input  logic [31:0]           op_y,
    input  fp_mul_pkg::rnd_mode_e rnd_mode,
    output logic                  out_valid,
    output logic [31:0]           res_z,
    output logic                  flag_ovrf,
    output logic                  flag_udrf,
    output logic                  flag_zer,
    output logic                  flag_inf,
    output logic                  flag_nan
);

    // Stage 1 registers and the Booth product
    logic                          s1_valid;
    logic [31:0]                   s1_op_x;
    logic [31:0]                   s1_op_y;
    fp_mul_pkg::rnd_mode_e         s1_rnd_mode;
    logic                          s1_sign;
    logic [fp_mul_pkg::frac_w:0]   s1_sig_x;
    logic [fp_mul_pkg::frac_w:0]   s1_sig_y;
    logic [fp_mul_pkg::prod_w-1:0] s1_prod_full;
    fp_mul_pkg::op_class_e         s1_cls_x;
    fp_mul_pkg::op_class_e         s1_cls_y;

    // Stage 2 registers and the combinational result
    logic                          s2_valid;
    logic [fp_mul_pkg::prod_w-1:0] s2_prod_full;
    logic                          s2_sign;
    logic [fp_mul_pkg::exp_w-1:0]  s2_exp_x;
    logic [fp_mul_pkg::exp_w-1:0]  s2_exp_y;
    fp_mul_pkg::rnd_mode_e         s2_rnd_mode;
    fp_mul_pkg::op_class_e         s2_cls_x;
    fp_mul_pkg::op_class_e         s2_cls_y;
    logic [fp_mul_pkg::norm_w-1:0] s2_frac_norm;
    logic                          s2_norm_n;
    logic                          s2_norm_r;
    logic [fp_mul_pkg::frac_w-1:0] s2_frac_rnd;
    logic [31:0]                   s2_res;
    logic                          s2_ovrf;
    logic                          s2_udrf;
    logic                          s2_zer;
    logic                          s2_inf;
    logic                          s2_nan;

    // Input capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            s1_op_x     <= '0;
            s1_op_y     <= '0;
            s1_rnd_mode <= fp_mul_pkg::rne;
        end else begin
            s1_valid    <= in_valid;
            s1_op_x     <= op_x;
            s1_op_y     <= op_y;
            s1_rnd_mode <= rnd_mode;
        end
    end

    assign s1_sign = s1_op_x[31] ^ s1_op_y[31];

    // Hidden bit drops out for a zero exponent, subnormals flush
    assign s1_sig_x = {|s1_op_x[30:23], s1_op_x[22:0]};
    assign s1_sig_y = {|s1_op_y[30:23], s1_op_y[22:0]};

    fp_mul_booth u_booth (
        .sig_a     (s1_sig_x),
        .sig_b     (s1_sig_y),
        .prod_full (s1_prod_full)
    );

    // Product, exponents and classes cross into stage 2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid     <= 1'b0;
            s2_prod_full <= '0;
            s2_sign      <= 1'b0;
            s2_exp_x     <= '0;
            s2_exp_y     <= '0;
            s2_rnd_mode  <= fp_mul_pkg::rne;
            s2_cls_x     <= fp_mul_pkg::zero;
            s2_cls_y     <= fp_mul_pkg::zero;
        end else begin
            s2_valid     <= s1_valid;
            s2_prod_full <= s1_prod_full;
            s2_sign      <= s1_sign;
            s2_exp_x     <= s1_op_x[30:23];
            s2_exp_y     <= s1_op_y[30:23];
            s2_rnd_mode  <= s1_rnd_mode;
            s2_cls_x     <= s1_cls_x;
            s2_cls_y     <= s1_cls_y;
        end
    end

    fp_mul_norm u_norm (
        .prod_full (s2_prod_full),
        .frac_norm (s2_frac_norm),
        .norm_n    (s2_norm_n)
    );

    fp_mul_round u_round (
        .frac_norm (s2_frac_norm),
        .sign      (s2_sign),
        .rnd_mode  (s2_rnd_mode),
        .frac_rnd  (s2_frac_rnd),
        .norm_r    (s2_norm_r)
    );

    // Classification runs on stage 1, packing on stage 2
    fp_mul_exp u_exp (
        .op_x     (s1_op_x),
        .op_y     (s1_op_y),
        .class_x  (s1_cls_x),
        .class_y  (s1_cls_y),
        .exp_x    (s2_exp_x),
        .exp_y    (s2_exp_y),
        .cls_x_r  (s2_cls_x),
        .cls_y_r  (s2_cls_y),
        .sign     (s2_sign),
        .norm_n   (s2_norm_n),
        .norm_r   (s2_norm_r),
        .frac_rnd (s2_frac_rnd),
        .res      (s2_res),
        .ovrf     (s2_ovrf),
        .udrf     (s2_udrf),
        .zer      (s2_zer),
        .inf      (s2_inf),
        .nan      (s2_nan)
    );

    // Output registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            res_z     <= '0;
            flag_ovrf <= 1'b0;
            flag_udrf <= 1'b0;
            flag_zer  <= 1'b0;
            flag_inf  <= 1'b0;
            flag_nan  <= 1'b0;
        end else begin
            out_valid <= s2_valid;
            res_z     <= s2_res;
            flag_ovrf <= s2_ovrf;
            flag_udrf <= s2_udrf;
            flag_zer  <= s2_zer;
            flag_inf  <= s2_inf;
            flag_nan  <= s2_nan;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run, the result is taken from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module fp_mul_tb -f all.f -o fp_mul_sim || exit 1
out=$(./obj_dir/fp_mul_sim)
echo "$out"
echo "$out" | grep -qx ">>> PASS" && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== verification/fp_mul_assertions.sv ====
`timescale 1ns/1ps

module fp_mul_assertions (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          s1_valid,
    input logic [fp_mul_pkg::frac_w:0]   s1_sig_x,
    input logic [fp_mul_pkg::frac_w:0]   s1_sig_y,
    input logic [fp_mul_pkg::prod_w-1:0] s1_prod_full,
    input logic                          s2_valid,
    input fp_mul_pkg::op_class_e         s2_cls_x,
    input fp_mul_pkg::op_class_e         s2_cls_y,
    input logic [fp_mul_pkg::norm_w-1:0] s2_frac_norm,
    input logic                          out_valid,
    input logic [31:0]                   res_z,
    input logic                          flag_zer,
    input logic                          flag_inf,
    input logic                          flag_nan
);

    logic [fp_mul_pkg::prod_w-1:0] prod_ref;

    // Plain multiply, widened to the product width
    assign prod_ref = s1_sig_x * s1_sig_y;

    booth_product: assert property (@(posedge clk) disable iff (!rst_n)
        s1_valid |-> s1_prod_full == prod_ref)
        else $error("Booth product differs from the plain product of the significands");

    // Two normal significands multiply into [1,4), leading one at the top
    norm_lead: assert property (@(posedge clk) disable iff (!rst_n)
        s2_valid && s2_cls_x == fp_mul_pkg::normal && s2_cls_y == fp_mul_pkg::normal
        |-> s2_frac_norm[fp_mul_pkg::norm_w-1])
        else $error("normalized significand has no leading one for normal operands");

    flag_excl: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({flag_nan, flag_inf, flag_zer}))
        else $error("more than one of the nan, inf and zero flags is set");

    nan_word: assert property (@(posedge clk) disable iff (!rst_n)
        flag_nan |-> res_z == fp_mul_pkg::qnan)
        else $error("nan flag set without the canonical quiet NaN word");

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid is high while reset is asserted");

endmodule

bind fp_mul_top fp_mul_assertions asrt_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .s1_valid     (s1_valid),
    .s1_sig_x     (s1_sig_x),
    .s1_sig_y     (s1_sig_y),
    .s1_prod_full (s1_prod_full),
    .s2_valid     (s2_valid),
    .s2_cls_x     (s2_cls_x),
    .s2_cls_y     (s2_cls_y),
    .s2_frac_norm (s2_frac_norm),
    .out_valid    (out_valid),
    .res_z        (res_z),
    .flag_zer     (flag_zer),
    .flag_inf     (flag_inf),
    .flag_nan     (flag_nan)
);

// ==== verification/fp_mul_monitor.sv ====
`timescale 1ns/1ps

module fp_mul_monitor (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [31:0] op_x,
    input  logic [31:0] op_y,
    input  logic [2:0]  rnd_mode,
    input  logic        out_valid,
    input  logic [31:0] res_z,
    input  logic        flag_ovrf,
    input  logic        flag_udrf,
    input  logic        flag_zer,
    input  logic        flag_inf,
    input  logic        flag_nan,
    output int          err_count,
    output int          n_in,
    output int          n_out
);

    // Rising edges from capture of the operands to the result
    localparam int latency = 2;

    // Entry holds operands, mode, expected word and flags {ovrf, udrf, zer, inf, nan}
    logic [103:0] exp_q [$];
    // Rising edge that captures each queued operation
    int           edge_q [$];
    logic [103:0] ent;
    int           cap_edge;
    int           edge_cnt;
    logic [4:0]   flags;

    assign flags = {flag_ovrf, flag_udrf, flag_zer, flag_inf, flag_nan};

    // Subnormals count as zero
    function automatic fp_mul_pkg::op_class_e class_of(input logic [31:0] v);
        if (v[30:23] == 8'h00) begin
            return fp_mul_pkg::zero;
        end else if (v[30:23] != fp_mul_pkg::exp_max) begin
            return fp_mul_pkg::normal;
        end
        return (v[22:0] == '0) ? fp_mul_pkg::infinite : fp_mul_pkg::nan;
    endfunction

    // Reference result from the IEEE rules with flush to zero
    function automatic logic [36:0] expect_of(input logic [31:0] x, input logic [31:0] y,
                                              input logic [2:0] mode);
        fp_mul_pkg::op_class_e cx;
        fp_mul_pkg::op_class_e cy;
        logic                  s;
        logic                  g;
        logic                  st;
        logic                  inc;
        logic [47:0]           p;
        logic [24:0]           sig;
        int                    e;
        cx = class_of(x);
        cy = class_of(y);
        s  = x[31] ^ y[31];
        if (cx == fp_mul_pkg::nan || cy == fp_mul_pkg::nan
            || (cx == fp_mul_pkg::infinite && cy == fp_mul_pkg::zero)
            || (cx == fp_mul_pkg::zero && cy == fp_mul_pkg::infinite)) begin
            return {fp_mul_pkg::qnan, 5'b00001};
        end else if (cx == fp_mul_pkg::infinite || cy == fp_mul_pkg::infinite) begin
            return {s, fp_mul_pkg::exp_max, 23'h0, 5'b00010};
        end else if (cx == fp_mul_pkg::zero || cy == fp_mul_pkg::zero) begin
            return {s, 31'h0, 5'b00100};
        end
        p = {24'h0, 1'b1, x[22:0]} * {24'h0, 1'b1, y[22:0]};
        e = int'(x[30:23]) + int'(y[30:23]) - fp_mul_pkg::exp_bias;
        // Product in [2,4) bumps the exponent instead of a shift
        if (p[47]) begin
            e++;
        end else begin
            p = p << 1;
        end
        g  = p[23];
        st = |p[22:0];
        case (mode)
            fp_mul_pkg::rtz: inc = 1'b0;
            fp_mul_pkg::rdn: inc = s & (g | st);
            fp_mul_pkg::rup: inc = ~s & (g | st);
            fp_mul_pkg::rmm: inc = g;
            default:         inc = g & (st | p[24]);
        endcase
        sig = {1'b0, p[47:24]} + {24'h0, inc};
        // Carry out of 1.111..1 lands on 2.0
        if (sig[24]) begin
            e++;
        end
        if (e >= 255) begin
            return {s, fp_mul_pkg::exp_max, 23'h0, 5'b10010};
        end else if (e <= 0) begin
            return {s, 31'h0, 5'b01100};
        end
        return {s, 8'(e), sig[22:0], 5'b00000};
    endfunction

    // Rising edges since the start of the run
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // Falling edge sees inputs and outputs settled
    always @(negedge clk) begin
        if (!rst_n) begin
            if (out_valid || res_z != '0 || flags != '0) begin
                $display("ERROR at %0t: outputs are not quiet while reset is asserted", $time);
                err_count++;
            end
        end else begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR at %0t: out_valid is high with no operation in flight", $time);
                    err_count++;
                end else begin
                    ent      = exp_q.pop_front();
                    cap_edge = edge_q.pop_front();
                    n_out++;
                    if (edge_cnt - cap_edge != latency) begin
                        $display("ERROR at %0t: result came %0d cycles after its operands, not %0d",
                                 $time, edge_cnt - cap_edge, latency);
                        err_count++;
                    end
                    if ({res_z, flags} != ent[36:0]) begin
                        $display("MISMATCH at %0t: x=%h y=%h mode=%0d exp %h/%b got %h/%b",
                                 $time, ent[103:72], ent[71:40], ent[39:37], ent[36:5],
                                 ent[4:0], res_z, flags);
                        err_count++;
                    end
                end
            end
            if (in_valid) begin
                exp_q.push_back({op_x, op_y, rnd_mode, expect_of(op_x, op_y, rnd_mode)});
                // The next rising edge captures this operation
                edge_q.push_back(edge_cnt + 1);
                n_in++;
            end
        end
    end

endmodule

// ==== verification/fp_mul_tb.sv ====
`timescale 1ns/1ps

module fp_mul_tb;

    localparam int n_rand  = 250;
    localparam int n_one   = 40;
    localparam int n_limit = 60;
    localparam int n_gap   = 150;
    // Worst case: up to 3 idle cycles before each op of the gap test, plus drains
    localparam int wd_ns   = (n_rand + 16 + 2 * n_one + n_limit + 27 + 4 * n_gap + 100) * 40
                             + 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic [31:0]           op_x;
    logic [31:0]           op_y;
    fp_mul_pkg::rnd_mode_e rnd_mode;
    logic                  out_valid;
    logic [31:0]           res_z;
    logic                  flag_ovrf;
    logic                  flag_udrf;
    logic                  flag_zer;
    logic                  flag_inf;
    logic                  flag_nan;
    int                    err_count;
    int                    n_in;
    int                    n_out;
    int                    sent;
    int                    err_mark;
    int                    in_mark;
    logic [31:0]           lcg_state = 32'h32d;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    fp_mul_top dut_i (
        .clk (clk), .rst_n (rst_n), .in_valid (in_valid), .op_x (op_x), .op_y (op_y),
        .rnd_mode (rnd_mode), .out_valid (out_valid), .res_z (res_z),
        .flag_ovrf (flag_ovrf), .flag_udrf (flag_udrf), .flag_zer (flag_zer),
        .flag_inf (flag_inf), .flag_nan (flag_nan)
    );

    fp_mul_monitor mon_i (
        .clk (clk), .rst_n (rst_n), .in_valid (in_valid), .op_x (op_x), .op_y (op_y),
        .rnd_mode (rnd_mode), .out_valid (out_valid), .res_z (res_z),
        .flag_ovrf (flag_ovrf), .flag_udrf (flag_udrf), .flag_zer (flag_zer),
        .flag_inf (flag_inf), .flag_nan (flag_nan),
        .err_count (err_count), .n_in (n_in), .n_out (n_out)
    );

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits, the low LCG bits repeat too quickly
    function int rand_below(input int n);
        return int'((next_rand() >> 8) % n);
    endfunction

    function logic [31:0] rand_normal(input int e_lo, input int e_hi);
        logic [31:0] r;
        r = next_rand();
        return {r[31], 8'(e_lo + rand_below(e_hi - e_lo + 1)), r[22:0]};
    endfunction

    task automatic send_op(input logic [31:0] x, input logic [31:0] y, input logic [2:0] m);
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        op_x     = x;
        op_y     = y;
        rnd_mode = fp_mul_pkg::rnd_mode_e'(m);
        sent++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    // Wait until every op sent has come back, then report this test
    task automatic finish_test(input string name);
        idle_cycle();
        while (n_in != sent || n_out != n_in) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("test %-18s ops %4d errors %0d", name, n_in - in_mark, err_count - err_mark);
        in_mark  = n_in;
        err_mark = err_count;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] x;
        int          ex;
        int          tgt;
        in_valid = 1'b0;
        op_x     = '0;
        op_y     = '0;
        rnd_mode = fp_mul_pkg::rne;
        rst_n    = 1'b1;
        #2;
        apply_reset();
        // Back to back normals, exponents kept clear of the range limits
        for (int i = 0; i < n_rand; i++) begin
            send_op(rand_normal(70, 180), rand_normal(70, 180), 3'(i % 5));
        end
        finish_test("random_normal");
        // Zeros, subnormals, infinities, NaNs and invalid pairs
        send_op(32'h00000000, 32'h3fc00000, 3'(rand_below(5)));
        send_op(32'h80000000, 32'h40490fdb, 3'(rand_below(5)));
        send_op(32'h00400000, 32'h3f800000, 3'(rand_below(5)));
        send_op(32'h807fffff, 32'hc0000000, 3'(rand_below(5)));
        send_op(32'h7f800000, 32'h3f800000, 3'(rand_below(5)));
        send_op(32'hff800000, 32'h40000000, 3'(rand_below(5)));
        send_op(32'h7f800000, 32'hff800000, 3'(rand_below(5)));
        send_op(32'h7fc00000, 32'h3f800000, 3'(rand_below(5)));
        send_op(32'h3f800000, 32'hffc12345, 3'(rand_below(5)));
        send_op(32'h7f800001, 32'h40000000, 3'(rand_below(5)));
        send_op(32'h7f800000, 32'h00000000, 3'(rand_below(5)));
        send_op(32'h80000000, 32'hff800000, 3'(rand_below(5)));
        send_op(32'h00000001, 32'h7f800000, 3'(rand_below(5)));
        send_op(32'h7fc00000, 32'h7f800000, 3'(rand_below(5)));
        send_op(32'h00000000, 32'h80000000, 3'(rand_below(5)));
        send_op(32'h7f800000, 32'h7f800000, 3'(rand_below(5)));
        finish_test("special_operands");
        // Identity on either side
        for (int i = 0; i < n_one; i++) begin
            x = rand_normal(1, 254);
            send_op(x, 32'h3f800000, 3'(i % 5));
            send_op(32'h3f800000, x, 3'(i % 5));
        end
        finish_test("times_one");
        // Exponent sums around the overflow and underflow limits
        for (int i = 0; i < n_limit; i++) begin
            r   = next_rand();
            x   = next_rand();
            tgt = (i % 2 == 0) ? 379 + rand_below(7) : 124 + rand_below(7);
            ex  = (i % 2 == 0) ? 190 + rand_below(20) : 40 + rand_below(40);
            send_op({r[31], 8'(ex), r[22:0]}, {x[31], 8'(tgt - ex), x[22:0]},
                    3'(rand_below(5)));
        end
        // Significand product 2^47-2 rounds up to 2.0 in some modes
        for (int m = 0; m < 5; m++) begin
            send_op(32'h3ffffffe, 32'h3f800001, 3'(m));
            send_op(32'hbffffffe, 32'h3f800001, 3'(m));
            send_op(32'h7f7ffffe, 32'h3f800001, 3'(m));
            send_op(32'hff7ffffe, 32'h3f800001, 3'(m));
            send_op(32'h00fffffe, 32'h3f000001, 3'(m));
        end
        send_op(32'h00800000, 32'h3f000000, 3'd0);
        send_op(32'h00800000, 32'h3f800000, 3'd0);
        finish_test("range_limits");
        // Second reset, then any operand words with idle gaps
        #2;
        apply_reset();
        for (int i = 0; i < n_gap; i++) begin
            repeat (rand_below(4)) idle_cycle();
            send_op(next_rand(), next_rand(), 3'(rand_below(5)));
        end
        finish_test("gaps_after_reset");
        $display("summary: %0d ops sent, %0d results checked, %0d errors",
                 sent, n_out, err_count);
        if (err_count == 0 && n_out == sent) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(wd_ns);
        $display("Watchdog expired after %0d ns, results are still outstanding", wd_ns);
        $display(">>> FAIL");
        $finish;
    end

endmodule
